// ==== hw/exePkg.sv ====
`default_nettype none

package exePkg;

    localparam int XLEN        = 64;
    localparam int WORD        = 32;
    localparam int INSTR_BYTES = 4;
    localparam int SHAMT       = 6;   // shift amount bits for 64-bit ops
    localparam int SHAMT_W     = 5;   // shift amount bits for word ops

    // encoding follows the alu mux select
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        AND  = 4'd1,
        OR   = 4'd2,
        SUB  = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9,
        ADDW = 4'd10,
        SUBW = 4'd11,
        SLLW = 4'd12,
        SRLW = 4'd13,
        SRAW = 4'd14
    } aluOpE;

    // branch funct3 values
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } cmpFuncE;

    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JAL    = 2'd2,
        KIND_JALR   = 2'd3
    } instKindE;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] opA;   // alu operands chosen by decode
        logic [XLEN-1:0] opB;
        logic [XLEN-1:0] rs1;   // compare operands
        logic [XLEN-1:0] rs2;
        aluOpE           aluOp;
        cmpFuncE         cmpFunc;
        instKindE        kind;
    } exeReqT;

    typedef struct packed {
        logic            valid;
        logic            rdWrite;
        logic [XLEN-1:0] rdData;
        logic [XLEN-1:0] nextPc;
        logic            taken;
    } exeRespT;

endpackage

`default_nettype wire

// ==== hw/intAlu.sv ====
`default_nettype none

module intAlu (
    input  logic [exePkg::XLEN-1:0] opA,
    input  logic [exePkg::XLEN-1:0] opB,
    input  exePkg::aluOpE           aluOp,
    output logic [exePkg::XLEN-1:0] aluResult
);

    // sign extension of a word result to full width
    function automatic logic [exePkg::XLEN-1:0] sextWord(input logic [exePkg::WORD-1:0] w);
        return {{(exePkg::XLEN - exePkg::WORD){w[exePkg::WORD-1]}}, w};
    endfunction

    logic [exePkg::XLEN-1:0]    resAdd;
    logic [exePkg::XLEN-1:0]    resSub;
    logic [exePkg::XLEN-1:0]    resAnd;
    logic [exePkg::XLEN-1:0]    resOr;
    logic [exePkg::XLEN-1:0]    resXor;
    logic                       lessS;
    logic                       lessU;
    logic [exePkg::SHAMT-1:0]   shamt;
    logic [exePkg::XLEN-1:0]    resSll;
    logic [exePkg::XLEN-1:0]    resSrl;
    logic [exePkg::XLEN-1:0]    resSra;

    logic [exePkg::WORD-1:0]    lowA;
    logic [exePkg::WORD-1:0]    lowB;
    logic [exePkg::SHAMT_W-1:0] shamtW;
    logic [exePkg::WORD-1:0]    resAddW;
    logic [exePkg::WORD-1:0]    resSubW;
    logic [exePkg::WORD-1:0]    resSllW;
    logic [exePkg::WORD-1:0]    resSrlW;
    logic [exePkg::WORD-1:0]    resSraW;

    // full width arithmetic and logic
    assign resAdd = opA + opB;
    assign resSub = opA - opB;
    assign resAnd = opA & opB;
    assign resOr  = opA | opB;
    assign resXor = opA ^ opB;

    // true signed and unsigned compares
    assign lessS = $signed(opA) < $signed(opB);
    assign lessU = opA < opB;

    assign shamt  = opB[exePkg::SHAMT-1:0];   // 0..63
    assign resSll = opA << shamt;
    assign resSrl = opA >> shamt;
    assign resSra = $unsigned($signed(opA) >>> shamt);

    // word ops only look at the low halves
    assign lowA   = opA[exePkg::WORD-1:0];
    assign lowB   = opB[exePkg::WORD-1:0];
    assign shamtW = opB[exePkg::SHAMT_W-1:0]; // bit 5 ignored

    assign resAddW = lowA + lowB;
    assign resSubW = lowA - lowB;
    assign resSllW = lowA << shamtW;
    assign resSrlW = lowA >> shamtW;
    assign resSraW = $unsigned($signed(lowA) >>> shamtW);

    always_comb begin
        case (aluOp)
            exePkg::ADD:  aluResult = resAdd;
            exePkg::SUB:  aluResult = resSub;
            exePkg::AND:  aluResult = resAnd;
            exePkg::OR:   aluResult = resOr;
            exePkg::XOR:  aluResult = resXor;
            exePkg::SLT:  aluResult = {{(exePkg::XLEN-1){1'b0}}, lessS};
            exePkg::SLTU: aluResult = {{(exePkg::XLEN-1){1'b0}}, lessU};
            exePkg::SLL:  aluResult = resSll;
            exePkg::SRL:  aluResult = resSrl;
            exePkg::SRA:  aluResult = resSra;
            exePkg::ADDW: aluResult = sextWord(resAddW);
            exePkg::SUBW: aluResult = sextWord(resSubW);
            exePkg::SLLW: aluResult = sextWord(resSllW);
            exePkg::SRLW: aluResult = sextWord(resSrlW); // srlw sign-extends too
            exePkg::SRAW: aluResult = sextWord(resSraW);
            default:      aluResult = '0;                // code 15 unused
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/branchCompare.sv ====
`default_nettype none

module branchCompare (
    input  logic [exePkg::XLEN-1:0] rs1,
    input  logic [exePkg::XLEN-1:0] rs2,
    input  exePkg::cmpFuncE         cmpFunc,
    output logic                    condTrue
);

    logic equal;
    logic lessS;
    logic lessU;
    logic baseCond;  // eq, lt or ltu before inversion
    logic known;     // function code is a real branch
    logic invert;

    assign equal = rs1 == rs2;
    assign lessS = $signed(rs1) < $signed(rs2);
    assign lessU = rs1 < rs2;

    // funct3 bit 0 turns beq/blt/bltu into bne/bge/bgeu
    assign invert = cmpFunc[0];

    always_comb begin
        known = 1'b1;
        case (cmpFunc)
            exePkg::BEQ, exePkg::BNE:   baseCond = equal;
            exePkg::BLT, exePkg::BGE:   baseCond = lessS;
            exePkg::BLTU, exePkg::BGEU: baseCond = lessU;
            default: begin
                baseCond = 1'b0;
                known    = 1'b0;  // codes 2 and 3 never branch
            end
        endcase
    end

    assign condTrue = known & (baseCond ^ invert);

endmodule

`default_nettype wire

// ==== hw/exeResolve.sv ====
`default_nettype none

module exeResolve (
    input  logic                    clk,
    input  logic                    arstN,
    input  exePkg::exeReqT          req,
    input  logic [exePkg::XLEN-1:0] aluResult,
    input  logic                    condTrue,
    output exePkg::exeRespT         resp
);

    logic [exePkg::XLEN-1:0] seqPc;
    logic [exePkg::XLEN-1:0] target;
    exePkg::exeRespT         respNext;

    // registered outputs
    logic                    validQ;
    logic                    rdWriteQ;
    logic                    takenQ;
    logic [exePkg::XLEN-1:0] rdDataQ;
    logic [exePkg::XLEN-1:0] nextPcQ;

    assign seqPc = req.pc + exePkg::XLEN'(exePkg::INSTR_BYTES);

    // jalr target has bit 0 forced low
    assign target = (req.kind == exePkg::KIND_JALR) ?
                    {aluResult[exePkg::XLEN-1:1], 1'b0} : aluResult;

    always_comb begin
        respNext.valid   = req.valid;
        respNext.rdWrite = 1'b0;
        respNext.rdData  = aluResult;
        respNext.nextPc  = seqPc;
        respNext.taken   = 1'b0;
        case (req.kind)
            exePkg::KIND_ALU: begin
                respNext.rdWrite = 1'b1;
            end
            exePkg::KIND_BRANCH: begin
                respNext.taken  = condTrue;
                respNext.nextPc = condTrue ? target : seqPc;
            end
            default: begin  // jal and jalr link pc+4
                respNext.rdWrite = 1'b1;
                respNext.rdData  = seqPc;
                respNext.nextPc  = target;
                respNext.taken   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ   <= 1'b0;
            rdWriteQ <= 1'b0;
            takenQ   <= 1'b0;
        end else begin
            validQ   <= respNext.valid;
            rdWriteQ <= respNext.rdWrite & req.valid; // bubbles never write
            takenQ   <= respNext.taken & req.valid;
        end
    end

    always_ff @(posedge clk) begin
        rdDataQ <= respNext.rdData;
        nextPcQ <= respNext.nextPc;
    end

    assign resp = '{valid: validQ, rdWrite: rdWriteQ, rdData: rdDataQ,
                    nextPc: nextPcQ, taken: takenQ};

endmodule

`default_nettype wire

// ==== hw/exeStage.sv ====
`default_nettype none

module exeStage (
    input  logic            clk,
    input  logic            arstN,
    input  exePkg::exeReqT  req,
    output exePkg::exeRespT resp
);

    logic [exePkg::XLEN-1:0] aluResult;
    logic                    condTrue;

    // alu and comparator run in parallel on the same request
    intAlu intAlu_i (
        .opA       (req.opA),
        .opB       (req.opB),
        .aluOp     (req.aluOp),
        .aluResult (aluResult)
    );

    branchCompare branchCompare_i (
        .rs1      (req.rs1),
        .rs2      (req.rs2),
        .cmpFunc  (req.cmpFunc),
        .condTrue (condTrue)
    );

    // one register stage lives here
    exeResolve exeResolve_i (
        .clk       (clk),
        .arstN     (arstN),
        .req       (req),
        .aluResult (aluResult),
        .condTrue  (condTrue),
        .resp      (resp)
    );

endmodule

`default_nettype wire

// ==== verif/exeModel.svh ====
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

function automatic logic [63:0] signExtWord(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// expected alu result straight from the instruction definitions
function automatic logic [63:0] aluRef(input logic [63:0] a, input logic [63:0] b,
                                       input exePkg::aluOpE op);
    logic [63:0] r;
    logic [31:0] w;
    logic [5:0]  sh;
    logic [4:0]  shW;
    sh  = b[5:0];
    shW = b[4:0];
    r   = a;
    w   = a[31:0];
    case (op)
        exePkg::ADD:  r = a + b;
        exePkg::SUB:  r = a + ~b + 64'd1;
        exePkg::AND:  r = a & b;
        exePkg::OR:   r = a | b;
        exePkg::XOR:  r = a ^ b;
        exePkg::SLT:  r = ((a ^ 64'h8000_0000_0000_0000) < (b ^ 64'h8000_0000_0000_0000))
                          ? 64'd1 : 64'd0;
        exePkg::SLTU: r = (a < b) ? 64'd1 : 64'd0;
        exePkg::SLL:  r = a << sh;
        exePkg::SRL:  r = a >> sh;
        exePkg::SRA:  repeat (sh) r = {r[63], r[63:1]};   // one bit at a time
        exePkg::ADDW: r = signExtWord(a[31:0] + b[31:0]);
        exePkg::SUBW: r = signExtWord(a[31:0] - b[31:0]);
        exePkg::SLLW: r = signExtWord(a[31:0] << shW);
        exePkg::SRLW: r = signExtWord(a[31:0] >> shW);
        exePkg::SRAW: begin
            repeat (shW) w = {w[31], w[31:1]};
            r = signExtWord(w);
        end
        default:      r = 64'd0;
    endcase
    return r;
endfunction

function automatic logic branchTaken(input logic [63:0] a, input logic [63:0] b,
                                     input exePkg::cmpFuncE fn);
    logic lt;
    lt = (a ^ 64'h8000_0000_0000_0000) < (b ^ 64'h8000_0000_0000_0000); // signed order
    case (fn)
        exePkg::BEQ:  return a == b;
        exePkg::BNE:  return a != b;
        exePkg::BLT:  return lt;
        exePkg::BGE:  return !lt;
        exePkg::BLTU: return a < b;
        exePkg::BGEU: return a >= b;
        default:      return 1'b0;
    endcase
endfunction

function automatic exePkg::exeRespT expectedResp(input exePkg::exeReqT r);
    exePkg::exeRespT e;
    logic [63:0]     link;
    logic [63:0]     target;
    link   = r.pc + 64'(exePkg::INSTR_BYTES);
    target = aluRef(r.opA, r.opB, r.aluOp);
    e        = '0;
    e.nextPc = link;
    if (r.valid) begin
        e.valid = 1'b1;
        case (r.kind)
            exePkg::KIND_ALU: begin
                e.rdWrite = 1'b1;
                e.rdData  = target;
            end
            exePkg::KIND_BRANCH: begin
                e.taken = branchTaken(r.rs1, r.rs2, r.cmpFunc);
                if (e.taken) e.nextPc = target;
            end
            default: begin
                e.rdWrite = 1'b1;
                e.rdData  = link;
                e.taken   = 1'b1;
                e.nextPc  = (r.kind == exePkg::KIND_JALR) ? (target & ~64'h1) : target;
            end
        endcase
    end
    return e;
endfunction

`endif

// ==== verif/exeStageTb.sv ====
`default_nettype none

module exeStageTb;

    `include "exeModel.svh"

    localparam int NUM_REQ  = 2000;
    localparam int WAIT_MAX = 20;

    logic            clk;
    logic            arstN;
    exePkg::exeReqT  req;
    exePkg::exeRespT resp;

    exePkg::exeRespT expQ[$];   // one entry in flight
    int              errors;
    int              checks;
    int              seedVal;
    int              n;
    bit              armed;

    exeStage dut_i (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .resp  (resp)
    );

    always #20 clk = ~clk;

    // extremes, small shift amounts and plain random values
    function automatic logic [63:0] pickOperand();
        case ($urandom_range(7))
            0:       return 64'h8000_0000_0000_0000;
            1:       return 64'h7fff_ffff_ffff_ffff;
            2:       return 64'hffff_ffff_ffff_ffff;
            3:       return 64'($urandom_range(63));
            4:       return {32'h0, $urandom};
            5:       return {$urandom | 32'h8000_0000, $urandom};
            default: return {$urandom, $urandom};
        endcase
    endfunction

    function automatic exePkg::exeReqT randomRequest();
        exePkg::exeReqT r;
        logic [3:0]     opBits;
        logic [2:0]     fnBits;
        logic [1:0]     kindBits;
        logic [12:0]    immBits;
        opBits    = 4'($urandom_range(14));
        fnBits    = 3'($urandom_range(7));
        kindBits  = 2'($urandom_range(3));
        immBits   = 13'($urandom);
        r         = '0;
        r.valid   = $urandom_range(99) < 80;
        r.pc      = {$urandom, $urandom} & ~64'h3;
        r.rs1     = pickOperand();
        r.rs2     = ($urandom_range(3) == 0) ? r.rs1 : pickOperand();
        r.cmpFunc = exePkg::cmpFuncE'(fnBits);
        r.kind    = exePkg::instKindE'(kindBits);
        r.aluOp   = exePkg::ADD;                       // targets are a plain add
        r.opB     = {{51{immBits[12]}}, immBits};
        case (r.kind)
            exePkg::KIND_ALU: begin
                r.aluOp = exePkg::aluOpE'(opBits);
                r.opA   = pickOperand();
                r.opB   = pickOperand();
            end
            exePkg::KIND_JALR: r.opA = r.rs1;
            default:           r.opA = r.pc;
        endcase
        return r;
    endfunction

    task automatic checkField(input string name, input logic [63:0] expV,
                              input logic [63:0] actV);
        if (actV !== expV) begin
            errors++;
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, expV, actV);
        end
    endtask

    task automatic compareResp(input exePkg::exeRespT e, input exePkg::exeRespT a);
        checkField("resp.valid", 64'(e.valid), 64'(a.valid));
        checkField("resp.rdWrite", 64'(e.rdWrite), 64'(a.rdWrite));
        checkField("resp.taken", 64'(e.taken), 64'(a.taken));
        if (e.valid) begin
            checkField("resp.nextPc", e.nextPc, a.nextPc);
            if (e.rdWrite) checkField("resp.rdData", e.rdData, a.rdData);
        end
    endtask

    task automatic finishRun();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // compare what the last edge captured, then record the request now on the bus
    always @(negedge clk) begin
        if (armed) begin
            if (expQ.size() > 0) begin
                compareResp(expQ.pop_front(), resp);
                checks++;
            end
            expQ.push_back(expectedResp(req));
        end
    end

    initial begin
        clk     = 1'b0;
        arstN   = 1'b0;
        req     = '0;
        errors  = 0;
        checks  = 0;
        armed   = 1'b0;
        seedVal = $urandom(82826);
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkField("resp.valid", 64'd0, 64'(resp.valid));   // flags cleared by reset
        checkField("resp.rdWrite", 64'd0, 64'(resp.rdWrite));
        checkField("resp.taken", 64'd0, 64'(resp.taken));
        @(posedge clk);
        arstN <= 1'b1;
        n = 0;
        while (arstN !== 1'b1 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (arstN !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end else begin
            armed = 1'b1;
            for (int i = 0; i < NUM_REQ; i++) begin
                @(posedge clk);
                req <= randomRequest();
            end
            @(posedge clk);
            req <= '0;
            n = 0;
            while (checks < NUM_REQ + 1 && n < WAIT_MAX) begin
                @(posedge clk);
                n++;
            end
            if (checks < NUM_REQ + 1) begin
                $display("timeout: responses did not drain, %0d compared", checks);
                errors++;
            end
            armed = 1'b0;
        end
        finishRun();
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verif
hw/exePkg.sv
hw/intAlu.sv
hw/branchCompare.sv
hw/exeResolve.sv
hw/exeStage.sv
verif/exeStageTb.sv
